// File: hw/rv_pkg.sv
package rv_pkg;

	localparam int xlen = 32;
	localparam int reg_idx_w = 5;

	localparam logic [6:0] op_lui = 7'b0110111;
	localparam logic [6:0] op_auipc = 7'b0010111;
	localparam logic [6:0] op_jal = 7'b1101111;
	localparam logic [6:0] op_jalr = 7'b1100111;
	localparam logic [6:0] op_branch = 7'b1100011;
	localparam logic [6:0] op_load = 7'b0000011;
	localparam logic [6:0] op_store = 7'b0100011;
	localparam logic [6:0] op_imm = 7'b0010011;
	localparam logic [6:0] op_reg = 7'b0110011;

	localparam logic [2:0] f3_byte = 3'b000;
	localparam logic [2:0] f3_half = 3'b001;
	localparam logic [2:0] f3_word = 3'b010;
	localparam logic [2:0] f3_byteu = 3'b100;
	localparam logic [2:0] f3_halfu = 3'b101;

	typedef logic [xlen-1:0] word_t;

	typedef enum logic [3:0] {
		alu_add, alu_sub, alu_sll, alu_slt, alu_sltu, alu_xor, alu_srl, alu_sra,
		alu_or, alu_and, alu_eq, alu_ne, alu_lt, alu_ge, alu_ltu, alu_geu
	} alu_op_t;

	typedef enum logic [3:0] {
		cls_alu_reg, cls_alu_imm, cls_lui, cls_auipc, cls_jal, cls_jalr,
		cls_branch, cls_load, cls_store, cls_none
	} inst_class_t;

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} r_fmt_t;

	typedef struct packed {
		logic [11:0] imm;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} i_fmt_t;

	typedef struct packed {
		logic [6:0] imm_hi;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] imm_lo;
		logic [6:0] opcode;
	} s_fmt_t;

	typedef struct packed {
		logic imm12;
		logic [5:0] imm10_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [3:0] imm4_1;
		logic imm11;
		logic [6:0] opcode;
	} b_fmt_t;

	typedef struct packed {
		logic [19:0] imm;
		logic [4:0] rd;
		logic [6:0] opcode;
	} u_fmt_t;

	typedef struct packed {
		logic imm20;
		logic [9:0] imm10_1;
		logic imm11;
		logic [7:0] imm19_12;
		logic [4:0] rd;
		logic [6:0] opcode;
	} j_fmt_t;

	typedef union packed {
		r_fmt_t r_fmt;
		i_fmt_t i_fmt;
		s_fmt_t s_fmt;
		b_fmt_t b_fmt;
		u_fmt_t u_fmt;
		j_fmt_t j_fmt;
	} inst_word_u;

endpackage

// File: hw/rv_decoder.sv
`timescale 1ns/1ps

module rv_decoder (
	input logic clk,
	input logic rstn,
	input rv_pkg::inst_word_u inst,
	output logic [rv_pkg::reg_idx_w-1:0] rs1,
	output logic [rv_pkg::reg_idx_w-1:0] rs2,
	output logic [rv_pkg::reg_idx_w-1:0] rd,
	output rv_pkg::word_t imm,
	output rv_pkg::inst_class_t iclass,
	output rv_pkg::alu_op_t alu_op,
	output logic [2:0] funct3
);

	logic [6:0] opcode;
	logic [2:0] f3;
	logic [6:0] f7;
	logic alt;
	logic is_shift;
	logic ld_ok;
	logic st_ok;
	logic br_ok;
	logic reg_ok;
	logic imm_ok;
	rv_pkg::word_t i_imm;
	rv_pkg::word_t s_imm;
	rv_pkg::word_t b_imm;
	rv_pkg::word_t u_imm;
	rv_pkg::word_t j_imm;
	rv_pkg::alu_op_t ar_op;
	rv_pkg::alu_op_t br_op;
	rv_pkg::inst_class_t cls_c;
	rv_pkg::alu_op_t op_c;
	rv_pkg::word_t imm_c;
	logic use_rs1;
	logic use_rs2;
	logic use_rd;

	assign opcode = inst.r_fmt.opcode;
	assign f3 = inst.r_fmt.funct3;
	assign f7 = inst.r_fmt.funct7;
	assign alt = f7[5] && (opcode == rv_pkg::op_reg || f3 == 3'b101); // sub / sra select
	assign is_shift = (f3 == 3'b001) || (f3 == 3'b101);

	assign ld_ok = f3 inside {rv_pkg::f3_byte, rv_pkg::f3_half, rv_pkg::f3_word,
		rv_pkg::f3_byteu, rv_pkg::f3_halfu};
	assign st_ok = f3 inside {rv_pkg::f3_byte, rv_pkg::f3_half, rv_pkg::f3_word};
	assign br_ok = !(f3 inside {3'b010, 3'b011});
	assign reg_ok = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'b000 || f3 == 3'b101));
	assign imm_ok = !is_shift || (f7 == 7'h00) || (f7 == 7'h20 && f3 == 3'b101);

	assign i_imm = {{20{inst.i_fmt.imm[11]}}, inst.i_fmt.imm};
	assign s_imm = {{20{inst.s_fmt.imm_hi[6]}}, inst.s_fmt.imm_hi, inst.s_fmt.imm_lo};
	assign b_imm = {{19{inst.b_fmt.imm12}}, inst.b_fmt.imm12, inst.b_fmt.imm11,
		inst.b_fmt.imm10_5, inst.b_fmt.imm4_1, 1'b0};
	assign u_imm = {inst.u_fmt.imm, 12'd0};
	assign j_imm = {{11{inst.j_fmt.imm20}}, inst.j_fmt.imm20, inst.j_fmt.imm19_12,
		inst.j_fmt.imm11, inst.j_fmt.imm10_1, 1'b0};

	always_comb begin
		case (f3)
			3'b000: ar_op = alt ? rv_pkg::alu_sub : rv_pkg::alu_add;
			3'b001: ar_op = rv_pkg::alu_sll;
			3'b010: ar_op = rv_pkg::alu_slt;
			3'b011: ar_op = rv_pkg::alu_sltu;
			3'b100: ar_op = rv_pkg::alu_xor;
			3'b101: ar_op = alt ? rv_pkg::alu_sra : rv_pkg::alu_srl;
			3'b110: ar_op = rv_pkg::alu_or;
			default: ar_op = rv_pkg::alu_and;
		endcase
		case (f3)
			3'b000: br_op = rv_pkg::alu_eq;
			3'b001: br_op = rv_pkg::alu_ne;
			3'b100: br_op = rv_pkg::alu_lt;
			3'b101: br_op = rv_pkg::alu_ge;
			3'b110: br_op = rv_pkg::alu_ltu;
			default: br_op = rv_pkg::alu_geu;
		endcase
	end

	always_comb begin
		cls_c = rv_pkg::cls_none; // undefined encodings fall through as no-ops
		op_c = rv_pkg::alu_add;
		imm_c = '0;
		use_rs1 = 1'b0;
		use_rs2 = 1'b0;
		use_rd = 1'b0;
		case (opcode)
			rv_pkg::op_lui, rv_pkg::op_auipc: begin
				cls_c = (opcode == rv_pkg::op_lui) ? rv_pkg::cls_lui : rv_pkg::cls_auipc;
				imm_c = u_imm;
				use_rd = 1'b1;
			end
			rv_pkg::op_jal: begin
				cls_c = rv_pkg::cls_jal;
				imm_c = j_imm;
				use_rd = 1'b1;
			end
			rv_pkg::op_jalr: begin
				if (f3 == 3'b000) begin
					cls_c = rv_pkg::cls_jalr;
					imm_c = i_imm;
					use_rs1 = 1'b1;
					use_rd = 1'b1;
				end
			end
			rv_pkg::op_branch: begin
				if (br_ok) begin
					cls_c = rv_pkg::cls_branch;
					op_c = br_op;
					imm_c = b_imm;
					use_rs1 = 1'b1;
					use_rs2 = 1'b1;
				end
			end
			rv_pkg::op_load: begin
				if (ld_ok) begin
					cls_c = rv_pkg::cls_load;
					imm_c = i_imm;
					use_rs1 = 1'b1;
					use_rd = 1'b1;
				end
			end
			rv_pkg::op_store: begin
				if (st_ok) begin
					cls_c = rv_pkg::cls_store;
					imm_c = s_imm;
					use_rs1 = 1'b1;
					use_rs2 = 1'b1;
				end
			end
			rv_pkg::op_imm: begin
				if (imm_ok) begin
					cls_c = rv_pkg::cls_alu_imm;
					op_c = ar_op;
					imm_c = is_shift ? {27'd0, inst.r_fmt.rs2} : i_imm; // shamt
					use_rs1 = 1'b1;
					use_rd = 1'b1;
				end
			end
			rv_pkg::op_reg: begin
				if (reg_ok) begin
					cls_c = rv_pkg::cls_alu_reg;
					op_c = ar_op;
					use_rs1 = 1'b1;
					use_rs2 = 1'b1;
					use_rd = 1'b1;
				end
			end
			default: begin
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			iclass <= rv_pkg::cls_none;
			alu_op <= rv_pkg::alu_add;
			rs1 <= '0;
			rs2 <= '0;
			rd <= '0;
		end else begin
			iclass <= cls_c;
			alu_op <= op_c;
			rs1 <= use_rs1 ? inst.r_fmt.rs1 : '0;
			rs2 <= use_rs2 ? inst.r_fmt.rs2 : '0;
			rd <= use_rd ? inst.r_fmt.rd : '0;
		end
	end

	always_ff @(posedge clk) begin
		imm <= imm_c;
		funct3 <= f3;
	end

endmodule

// File: hw/rv_regfile.sv
`timescale 1ns/1ps

module rv_regfile (
	input logic clk,
	input logic rstn,
	input logic [rv_pkg::reg_idx_w-1:0] rs1_idx,
	input logic [rv_pkg::reg_idx_w-1:0] rs2_idx,
	input logic [rv_pkg::reg_idx_w-1:0] rd_idx,
	input logic rd_en,
	input rv_pkg::word_t rd_data,
	output rv_pkg::word_t rs1_data,
	output rv_pkg::word_t rs2_data
);

	rv_pkg::word_t regs [1:31]; // x0 has no storage

	always_ff @(posedge clk) begin
		if (!rstn) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (rd_en && rd_idx != '0) begin
			regs[rd_idx] <= rd_data;
		end
	end

	always_ff @(posedge clk) begin
		rs1_data <= (rs1_idx == '0) ? '0 : regs[rs1_idx];
		rs2_data <= (rs2_idx == '0) ? '0 : regs[rs2_idx];
	end

endmodule

// File: hw/rv_alu.sv
`timescale 1ns/1ps

module rv_alu (
	input logic clk,
	input logic rstn,
	input rv_pkg::alu_op_t op,
	input rv_pkg::word_t src1,
	input rv_pkg::word_t src2,
	output rv_pkg::word_t result
);

	logic [4:0] shamt;
	rv_pkg::word_t sum_r;
	rv_pkg::word_t diff_r;
	rv_pkg::word_t sll_r;
	rv_pkg::word_t srl_r;
	rv_pkg::word_t sra_r;
	rv_pkg::word_t xor_r;
	rv_pkg::word_t or_r;
	rv_pkg::word_t and_r;
	logic eq_r;
	logic lts_r;
	logic ltu_r;
	rv_pkg::alu_op_t op_d;

	assign shamt = src2[4:0];

	// stage 1, every candidate at once
	always_ff @(posedge clk) begin
		sum_r <= src1 + src2;
		diff_r <= src1 - src2;
		sll_r <= src1 << shamt;
		srl_r <= src1 >> shamt;
		sra_r <= $signed(src1) >>> shamt;
		xor_r <= src1 ^ src2;
		or_r <= src1 | src2;
		and_r <= src1 & src2;
		eq_r <= (src1 == src2);
		lts_r <= ($signed(src1) < $signed(src2));
		ltu_r <= (src1 < src2);
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			op_d <= rv_pkg::alu_add;
		end else begin
			op_d <= op;
		end
	end

	always_ff @(posedge clk) begin
		case (op_d)
			rv_pkg::alu_add: result <= sum_r;
			rv_pkg::alu_sub: result <= diff_r;
			rv_pkg::alu_sll: result <= sll_r;
			rv_pkg::alu_slt: result <= {31'd0, lts_r};
			rv_pkg::alu_sltu: result <= {31'd0, ltu_r};
			rv_pkg::alu_xor: result <= xor_r;
			rv_pkg::alu_srl: result <= srl_r;
			rv_pkg::alu_sra: result <= sra_r;
			rv_pkg::alu_or: result <= or_r;
			rv_pkg::alu_and: result <= and_r;
			rv_pkg::alu_eq: result <= {31'd0, eq_r};
			rv_pkg::alu_ne: result <= {31'd0, !eq_r};
			rv_pkg::alu_lt: result <= {31'd0, lts_r};
			rv_pkg::alu_ge: result <= {31'd0, !lts_r};
			rv_pkg::alu_ltu: result <= {31'd0, ltu_r};
			default: result <= {31'd0, !ltu_r}; // geu
		endcase
	end

endmodule

// File: hw/rv_mem_port.sv
`timescale 1ns/1ps

module rv_mem_port (
	input logic clk,
	input logic rstn,
	input logic rd_req,
	input logic wr_req,
	input rv_pkg::word_t addr,
	input logic [2:0] funct3,
	input rv_pkg::word_t wdata_in,
	output logic done,
	output rv_pkg::word_t rdata_out,
	output rv_pkg::word_t araddr,
	output logic arvalid,
	input logic arready,
	input rv_pkg::word_t rdata,
	input logic rvalid,
	output logic rready,
	output rv_pkg::word_t awaddr,
	output logic awvalid,
	input logic awready,
	output rv_pkg::word_t wdata,
	output logic [3:0] wstrb,
	output logic wvalid,
	input logic wready,
	input logic bvalid,
	output logic bready
);

	typedef enum logic [2:0] {ps_idle, ps_ar, ps_r, ps_aw_w, ps_b} port_state_t;

	port_state_t pstate;
	logic [1:0] lane_r;
	logic [2:0] f3_r;
	logic aw_done;
	logic w_done;
	rv_pkg::word_t shifted;
	rv_pkg::word_t load_ext;
	rv_pkg::word_t wdata_c;
	logic [3:0] strb_c;

	assign aw_done = !awvalid || awready;
	assign w_done = !wvalid || wready;

	always_comb begin
		shifted = rdata >> {lane_r, 3'b000}; // addressed lane down to bit 0
		case (f3_r)
			rv_pkg::f3_byte: load_ext = {{24{shifted[7]}}, shifted[7:0]};
			rv_pkg::f3_half: load_ext = {{16{shifted[15]}}, shifted[15:0]};
			rv_pkg::f3_byteu: load_ext = {24'd0, shifted[7:0]};
			rv_pkg::f3_halfu: load_ext = {16'd0, shifted[15:0]};
			default: load_ext = rdata;
		endcase
	end

	always_comb begin
		case (funct3)
			rv_pkg::f3_byte: begin
				wdata_c = {4{wdata_in[7:0]}};
				strb_c = 4'b0001 << addr[1:0];
			end
			rv_pkg::f3_half: begin
				wdata_c = {2{wdata_in[15:0]}};
				strb_c = addr[1] ? 4'b1100 : 4'b0011;
			end
			default: begin
				wdata_c = wdata_in;
				strb_c = 4'b1111;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			pstate <= ps_idle;
			arvalid <= 1'b0;
			rready <= 1'b0;
			awvalid <= 1'b0;
			wvalid <= 1'b0;
			bready <= 1'b0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			case (pstate)
				ps_idle: begin
					if (rd_req) begin
						arvalid <= 1'b1;
						pstate <= ps_ar;
					end else if (wr_req) begin
						awvalid <= 1'b1;
						wvalid <= 1'b1;
						pstate <= ps_aw_w;
					end
				end
				ps_ar: begin
					if (arready) begin
						arvalid <= 1'b0;
						rready <= 1'b1;
						pstate <= ps_r;
					end
				end
				ps_r: begin
					if (rvalid) begin
						rready <= 1'b0;
						done <= 1'b1;
						pstate <= ps_idle;
					end
				end
				ps_aw_w: begin
					if (awready) begin
						awvalid <= 1'b0;
					end
					if (wready) begin
						wvalid <= 1'b0;
					end
					if (aw_done && w_done) begin // either order
						bready <= 1'b1;
						pstate <= ps_b;
					end
				end
				default: begin
					if (bvalid) begin
						bready <= 1'b0;
						done <= 1'b1;
						pstate <= ps_idle;
					end
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (rd_req || wr_req) begin
			lane_r <= addr[1:0];
			f3_r <= funct3;
		end
		if (rd_req) begin
			araddr <= {addr[rv_pkg::xlen-1:2], 2'b00};
		end
		if (wr_req) begin
			awaddr <= {addr[rv_pkg::xlen-1:2], 2'b00};
			wdata <= wdata_c;
			wstrb <= strb_c;
		end
		if (rvalid && rready) begin
			rdata_out <= load_ext;
		end
	end

endmodule

// File: hw/rv_core.sv
`timescale 1ns/1ps

module rv_core (
	input logic clk,
	input logic rstn,
	output rv_pkg::word_t araddr,
	output logic arvalid,
	input logic arready,
	input rv_pkg::word_t rdata,
	input logic rvalid,
	output logic rready,
	output rv_pkg::word_t awaddr,
	output logic awvalid,
	input logic awready,
	output rv_pkg::word_t wdata,
	output logic [3:0] wstrb,
	output logic wvalid,
	input logic wready,
	input logic bvalid,
	output logic bready
);

	typedef enum logic [2:0] {
		st_wait, st_fetch, st_decode, st_read, st_exec1, st_exec2, st_mem, st_write
	} core_state_t;

	core_state_t state;
	rv_pkg::word_t pc;
	rv_pkg::inst_word_u inst_reg;
	rv_pkg::word_t load_data;
	logic mem_busy;

	logic [rv_pkg::reg_idx_w-1:0] rs1;
	logic [rv_pkg::reg_idx_w-1:0] rs2;
	logic [rv_pkg::reg_idx_w-1:0] rd;
	rv_pkg::word_t imm;
	rv_pkg::inst_class_t iclass;
	rv_pkg::alu_op_t alu_op;
	logic [2:0] funct3;
	rv_pkg::word_t rs1_data;
	rv_pkg::word_t rs2_data;
	rv_pkg::word_t alu_src2;
	rv_pkg::word_t alu_result;

	logic is_load;
	logic is_store;
	logic rd_req;
	logic wr_req;
	logic mem_done;
	rv_pkg::word_t mem_addr;
	logic [2:0] mem_f3;
	rv_pkg::word_t mem_rdata;

	rv_pkg::word_t pc_plus4;
	rv_pkg::word_t pc_plus_imm;
	rv_pkg::word_t jalr_sum;
	rv_pkg::word_t next_pc;
	rv_pkg::word_t wb_data;
	logic rd_en;

	rv_decoder u_decoder (
		.clk(clk), .rstn(rstn), .inst(inst_reg),
		.rs1(rs1), .rs2(rs2), .rd(rd), .imm(imm),
		.iclass(iclass), .alu_op(alu_op), .funct3(funct3)
	);

	rv_regfile u_regfile (
		.clk(clk), .rstn(rstn), .rs1_idx(rs1), .rs2_idx(rs2), .rd_idx(rd),
		.rd_en(rd_en), .rd_data(wb_data), .rs1_data(rs1_data), .rs2_data(rs2_data)
	);

	rv_alu u_alu (
		.clk(clk), .rstn(rstn), .op(alu_op),
		.src1(rs1_data), .src2(alu_src2), .result(alu_result)
	);

	rv_mem_port u_mem_port (
		.clk(clk), .rstn(rstn), .rd_req(rd_req), .wr_req(wr_req),
		.addr(mem_addr), .funct3(mem_f3), .wdata_in(rs2_data),
		.done(mem_done), .rdata_out(mem_rdata),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rvalid(rvalid), .rready(rready),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
		.bvalid(bvalid), .bready(bready)
	);

	assign is_load = (iclass == rv_pkg::cls_load);
	assign is_store = (iclass == rv_pkg::cls_store);
	assign alu_src2 = (iclass == rv_pkg::cls_alu_reg || iclass == rv_pkg::cls_branch) ?
		rs2_data : imm;

	// one request per fetch or data access
	assign rd_req = !mem_busy && (state == st_fetch || (state == st_mem && is_load));
	assign wr_req = !mem_busy && state == st_mem && is_store;
	assign mem_addr = (state == st_fetch) ? pc : alu_result; // alu adds rs1 + imm
	assign mem_f3 = (state == st_fetch) ? rv_pkg::f3_word : funct3;

	assign pc_plus4 = pc + 32'd4;
	assign pc_plus_imm = pc + imm;
	assign jalr_sum = rs1_data + imm;
	assign rd_en = (state == st_write); // rd is zero for non-writing classes

	always_comb begin
		case (iclass)
			rv_pkg::cls_lui: wb_data = imm;
			rv_pkg::cls_auipc: wb_data = pc_plus_imm;
			rv_pkg::cls_load: wb_data = load_data;
			rv_pkg::cls_jal, rv_pkg::cls_jalr: wb_data = pc_plus4;
			default: wb_data = alu_result;
		endcase
		case (iclass)
			rv_pkg::cls_jal: next_pc = pc_plus_imm;
			rv_pkg::cls_jalr: next_pc = {jalr_sum[rv_pkg::xlen-1:1], 1'b0};
			rv_pkg::cls_branch: next_pc = (alu_result != '0) ? pc_plus_imm : pc_plus4;
			default: next_pc = pc_plus4;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			state <= st_wait;
			pc <= '0;
			inst_reg <= '0;
			mem_busy <= 1'b0;
		end else begin
			if (rd_req || wr_req) begin
				mem_busy <= 1'b1;
			end else if (mem_done) begin
				mem_busy <= 1'b0;
			end
			case (state)
				st_wait: state <= st_fetch;
				st_fetch: begin
					if (mem_done) begin
						inst_reg <= mem_rdata;
						state <= st_decode;
					end
				end
				st_decode: state <= st_read;
				st_read: state <= st_exec1;
				st_exec1: state <= st_exec2;
				st_exec2: state <= (is_load || is_store) ? st_mem : st_write;
				st_mem: begin
					if (mem_done) begin
						state <= st_write;
					end
				end
				default: begin
					pc <= next_pc;
					state <= st_fetch;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == st_mem && mem_done) begin
			load_data <= mem_rdata;
		end
	end

endmodule

// File: bench/core_checker.sv
`timescale 1ns/1ps

module core_checker (
	input logic clk,
	input logic rstn,
	input logic arvalid,
	input logic arready,
	input logic rready,
	input logic awvalid,
	input logic awready,
	input logic wvalid,
	input logic [3:0] wstrb
);

	ar_hold: assert property (@(posedge clk) disable iff (!rstn)
		arvalid && !arready |=> arvalid)
		else $error("arvalid dropped before arready");

	aw_hold: assert property (@(posedge clk) disable iff (!rstn)
		awvalid && !awready |=> awvalid)
		else $error("awvalid dropped before awready");

	// one outstanding read, so no overlap
	rd_excl: assert property (@(posedge clk) disable iff (!rstn) !(rready && arvalid))
		else $error("rready and arvalid high together");

	strb_set: assert property (@(posedge clk) disable iff (!rstn) wvalid |-> wstrb != 4'd0)
		else $error("wvalid with empty wstrb");

endmodule

// File: bench/core_monitor.sv
`timescale 1ns/1ps

module core_monitor (
	input logic clk,
	input logic rstn,
	input logic [31:0] araddr,
	input logic arvalid,
	input logic arready,
	input logic [31:0] awaddr,
	input logic awvalid,
	input logic awready,
	input logic [31:0] wdata,
	input logic [3:0] wstrb,
	input logic wvalid,
	input logic wready,
	input logic bready,
	input logic [31:0] exp_addr [0:63],
	input logic [3:0] exp_strb [0:63],
	input logic [31:0] exp_data [0:63],
	input int exp_count,
	output int store_count,
	output int mismatch_count,
	output int extra_count,
	output int protocol_count
);

	logic aw_seen;
	logic w_seen;
	logic [31:0] cap_addr;
	logic [31:0] cap_data;
	logic [3:0] cap_strb;

	task automatic compare_field(input string name, input logic [31:0] got,
		input logic [31:0] exp, inout int n);
		if (got !== exp) begin
			$display("MISMATCH t=%0t %s got %h expected %h", $time, name, got, exp);
			n++;
		end
	endtask

	initial begin
		store_count = 0;
		mismatch_count = 0;
		extra_count = 0;
		protocol_count = 0;
	end

	always @(posedge clk) begin
		int n;
		n = 0;
		if (!rstn) begin
			aw_seen = 1'b0;
			w_seen = 1'b0;
		end else begin
			if (arvalid && arready) begin // read address is word aligned
				compare_field("araddr[1:0]", {30'd0, araddr[1:0]}, 32'd0, n);
			end
			if (bready && (awvalid || wvalid)) begin
				$display("bready high at t=%0t while the write address or data was still pending",
					$time);
				protocol_count <= protocol_count + 1;
			end
			if (awvalid && awready) begin
				aw_seen = 1'b1;
				cap_addr = awaddr;
			end
			if (wvalid && wready) begin
				w_seen = 1'b1;
				cap_data = wdata;
				cap_strb = wstrb;
			end
			if (aw_seen && w_seen) begin // one full store
				aw_seen = 1'b0;
				w_seen = 1'b0;
				if (store_count < exp_count) begin
					compare_field("awaddr", cap_addr, exp_addr[store_count], n);
					compare_field("wstrb", {28'd0, cap_strb}, {28'd0, exp_strb[store_count]}, n);
					compare_field("wdata", cap_data, exp_data[store_count], n);
				end else begin
					$display("unexpected store of %h to %h after the expected list ended",
						cap_data, cap_addr);
					extra_count <= extra_count + 1;
				end
				store_count <= store_count + 1;
			end
			mismatch_count <= mismatch_count + n;
		end
	end

endmodule

// File: bench/tb_core.sv
`timescale 1ns/1ps

module tb_core;

	localparam int max_exp = 64;
	localparam int run_limit = 20000;

	logic clk;
	logic rstn;
	logic [31:0] araddr;
	logic arvalid;
	logic arready;
	logic [31:0] rdata;
	logic rvalid;
	logic rready;
	logic [31:0] awaddr;
	logic awvalid;
	logic awready;
	logic [31:0] wdata;
	logic [3:0] wstrb;
	logic wvalid;
	logic wready;
	logic bvalid;
	logic bready;

	logic [31:0] mem [logic [29:0]]; // word addressed
	logic [31:0] exp_addr [0:max_exp-1];
	logic [3:0] exp_strb [0:max_exp-1];
	logic [31:0] exp_data [0:max_exp-1];
	int exp_count;
	int store_count;
	int mismatch_count;
	int extra_count;
	int protocol_count;
	int other_errors;

	logic [31:0] lfsr_state;

	// model state, sampled DUT outputs from the last edge
	logic s_arvalid, s_rready, s_awvalid, s_wvalid, s_bready;
	logic [31:0] s_araddr, s_awaddr, s_wdata;
	logic [3:0] s_wstrb;
	logic r_pend, b_pend, aw_seen, w_seen;
	int ar_cnt, aw_cnt, w_cnt, r_cnt, b_cnt;
	logic [31:0] rd_word;
	logic [31:0] wr_addr, wr_data;
	logic [3:0] wr_strb;

	rv_core uut (
		.clk(clk), .rstn(rstn),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rvalid(rvalid), .rready(rready),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
		.bvalid(bvalid), .bready(bready)
	);

	bind rv_core core_checker u_checker (
		.clk(clk), .rstn(rstn), .arvalid(arvalid), .arready(arready),
		.rready(rready), .awvalid(awvalid), .awready(awready),
		.wvalid(wvalid), .wstrb(wstrb)
	);

	core_monitor mon (
		.clk(clk), .rstn(rstn),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
		.bready(bready),
		.exp_addr(exp_addr), .exp_strb(exp_strb), .exp_data(exp_data),
		.exp_count(exp_count), .store_count(store_count),
		.mismatch_count(mismatch_count), .extra_count(extra_count),
		.protocol_count(protocol_count)
	);

	always #10 clk = ~clk;

	function automatic logic [31:0] lfsr_shift(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// two lfsr bits give 0 to 3 wait cycles
	task automatic draw_delay(output int d);
		d = 0;
		lfsr_state = lfsr_shift(lfsr_state);
		if (lfsr_state[0]) d += 1;
		lfsr_state = lfsr_shift(lfsr_state);
		if (lfsr_state[0]) d += 2;
	endtask

	function automatic logic [31:0] mem_read(input logic [29:0] k);
		if (mem.exists(k)) return mem[k];
		return ~{k, 2'b00}; // unwritten words read back their inverted address
	endfunction

	task automatic load_cases();
		int fd;
		int n;
		string line;
		logic [31:0] a;
		logic [31:0] s;
		logic [31:0] d;
		fd = $fopen("bench/core_cases.txt", "r");
		if (fd == 0) begin
			$display("could not open the case file bench/core_cases.txt");
			other_errors++;
			return;
		end
		while (!$feof(fd)) begin
			line = "";
			n = $fgets(line, fd);
			if (line.len() < 3 || line[0] == "#") continue;
			if (line[0] == "p") begin
				n = $sscanf(line.substr(2, line.len() - 1), "%h %h", a, d);
				if (n != 2) begin
					$display("malformed program line in the case file: %s", line);
					other_errors++;
				end else begin
					mem[a[31:2]] = d;
				end
			end else if (line[0] == "e" && exp_count < max_exp) begin
				n = $sscanf(line.substr(2, line.len() - 1), "%h %h %h", a, s, d);
				if (n != 3) begin
					$display("malformed expected store line in the case file: %s", line);
					other_errors++;
				end else begin
					exp_addr[exp_count] = a;
					exp_strb[exp_count] = s[3:0];
					exp_data[exp_count] = d;
					exp_count++;
				end
			end
		end
		$fclose(fd);
	endtask

	// bus memory, drives a small delay after each rising edge
	always @(posedge clk) begin
		logic [31:0] merged;
		#1;
		if (!rstn) begin
			arready = 1'b0;
			rvalid = 1'b0;
			awready = 1'b0;
			wready = 1'b0;
			bvalid = 1'b0;
			r_pend = 1'b0;
			b_pend = 1'b0;
			aw_seen = 1'b0;
			w_seen = 1'b0;
			s_arvalid = 1'b0;
			s_rready = 1'b0;
			s_awvalid = 1'b0;
			s_wvalid = 1'b0;
			s_bready = 1'b0;
		end else begin
			if (s_arvalid && arready) begin
				arready = 1'b0;
				rd_word = mem_read(s_araddr[31:2]);
				r_pend = 1'b1;
				draw_delay(r_cnt);
			end
			if (rvalid && s_rready) rvalid = 1'b0;
			if (s_awvalid && awready) begin
				awready = 1'b0;
				aw_seen = 1'b1;
				wr_addr = s_awaddr;
			end
			if (s_wvalid && wready) begin
				wready = 1'b0;
				w_seen = 1'b1;
				wr_data = s_wdata;
				wr_strb = s_wstrb;
			end
			if (aw_seen && w_seen) begin
				merged = mem_read(wr_addr[31:2]);
				for (int i = 0; i < 4; i++) begin
					if (wr_strb[i]) merged[i*8 +: 8] = wr_data[i*8 +: 8];
				end
				mem[wr_addr[31:2]] = merged;
				aw_seen = 1'b0;
				w_seen = 1'b0;
				b_pend = 1'b1;
				draw_delay(b_cnt);
			end
			if (bvalid && s_bready) bvalid = 1'b0;

			s_arvalid = arvalid;
			s_rready = rready;
			s_awvalid = awvalid;
			s_wvalid = wvalid;
			s_bready = bready;
			s_araddr = araddr;
			s_awaddr = awaddr;
			s_wdata = wdata;
			s_wstrb = wstrb;

			if (s_arvalid && !arready) begin
				if (ar_cnt == 0) begin
					arready = 1'b1;
					draw_delay(ar_cnt);
				end else ar_cnt--;
			end
			if (s_awvalid && !awready) begin
				if (aw_cnt == 0) begin
					awready = 1'b1;
					draw_delay(aw_cnt);
				end else aw_cnt--;
			end
			if (s_wvalid && !wready) begin
				if (w_cnt == 0) begin
					wready = 1'b1;
					draw_delay(w_cnt);
				end else w_cnt--;
			end
			if (r_pend) begin
				if (r_cnt == 0) begin
					rvalid = 1'b1;
					rdata = rd_word;
					r_pend = 1'b0;
				end else r_cnt--;
			end
			if (b_pend) begin
				if (b_cnt == 0) begin
					bvalid = 1'b1;
					b_pend = 1'b0;
				end else b_cnt--;
			end
		end
	end

	initial begin
		int cycles;
		logic timed_out;
		clk = 1'b0;
		rstn = 1'b0;
		arready = 1'b0;
		rdata = '0;
		rvalid = 1'b0;
		awready = 1'b0;
		wready = 1'b0;
		bvalid = 1'b0;
		lfsr_state = 32'h7fa0a3fa;
		exp_count = 0;
		other_errors = 0;
		ar_cnt = 0;
		aw_cnt = 0;
		w_cnt = 0;
		r_cnt = 0;
		b_cnt = 0;
		timed_out = 1'b0;
		load_cases();
		repeat (8) @(posedge clk);
		#1 rstn = 1'b1;

		cycles = 0;
		while (store_count < exp_count && cycles < run_limit) begin
			@(posedge clk);
			cycles++;
		end
		if (store_count < exp_count) begin
			$display("timeout: %0d of %0d expected stores seen after %0d cycles",
				store_count, exp_count, cycles);
			timed_out = 1'b1;
			other_errors++;
		end
		repeat (40) @(posedge clk); // catch stray stores after the marker

		$display("errors: mismatches=%0d extra_stores=%0d protocol=%0d other=%0d",
			mismatch_count, extra_count, protocol_count, other_errors);
		if (!timed_out && mismatch_count == 0 && extra_count == 0 && protocol_count == 0 &&
			other_errors == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

// File: bench/core_cases.txt
# p <byte address> <instruction word>
# e <store address> <wstrb> <wdata>, in program order
p 00000000 40000513
p 00000004 ff800093
p 00000008 00500113
p 0000000c 002081b3
p 00000010 00352023
p 00000014 40110233
p 00000018 00452223
p 0000001c 4020d293
p 00000020 01c0d313
p 00000024 0020a3b3
p 00000028 0020b433
p 0000002c 00552423
p 00000030 00652623
p 00000034 00752823
p 00000038 00852a23
p 0000003c 00411593
p 00000040 0025e633
p 00000044 0f00f693
p 00000048 fff6c713
p 0000004c 00c52c23
p 00000050 00e52e23
p 00000054 123457b7
p 00000058 00001817
p 0000005c 02f52023
p 00000060 03052223
p 00000064 008008ef
p 00000068 02152423
p 0000006c 03152423
p 00000070 08100993
p 00000074 00098967
p 00000078 02152423
p 0000007c 02152423
p 00000080 03252623
p 00000084 00210463
p 00000088 001a0a13
p 0000008c 00208463
p 00000090 010a0a13
p 00000094 03452823
p 00000098 00209463
p 0000009c 001a0a13
p 000000a0 00211463
p 000000a4 010a0a13
p 000000a8 03452823
p 000000ac 0020c463
p 000000b0 001a0a13
p 000000b4 00114463
p 000000b8 010a0a13
p 000000bc 03452823
p 000000c0 00115463
p 000000c4 001a0a13
p 000000c8 0020d463
p 000000cc 010a0a13
p 000000d0 03452823
p 000000d4 00116463
p 000000d8 001a0a13
p 000000dc 0020e463
p 000000e0 010a0a13
p 000000e4 03452823
p 000000e8 0020f463
p 000000ec 001a0a13
p 000000f0 00117463
p 000000f4 010a0a13
p 000000f8 03452823
p 000000fc 7a500a93
p 00000100 05550023
p 00000104 041500a3
p 00000108 04251123
p 0000010c 05551223
p 00000110 04250323
p 00000114 041503a3
p 00000118 04052c03
p 0000011c 04452c83
p 00000120 05852823
p 00000124 05952a23
p 00000128 04450d03
p 0000012c 05a52c23
p 00000130 04454d03
p 00000134 05a52e23
p 00000138 04550d03
p 0000013c 07a52023
p 00000140 04654d03
p 00000144 07a52223
p 00000148 04750d03
p 0000014c 07a52423
p 00000150 04451d03
p 00000154 07a52623
p 00000158 04651d03
p 0000015c 07a52823
p 00000160 04655d03
p 00000164 07a52a23
p 00000168 ffffffff
p 0000016c c0de5db7
p 00000170 0fb52e23
p 00000174 0000006f
e 00000400 f fffffffd
e 00000404 f 0000000d
e 00000408 f fffffffe
e 0000040c f 0000000f
e 00000410 f 00000001
e 00000414 f 00000000
e 00000418 f 00000055
e 0000041c f ffffff0f
e 00000420 f 12345000
e 00000424 f 00001058
e 00000428 f 00000068
e 0000042c f 00000078
e 00000430 f 00000010
e 00000430 f 00000020
e 00000430 f 00000030
e 00000430 f 00000040
e 00000430 f 00000050
e 00000430 f 00000060
e 00000440 1 a5a5a5a5
e 00000440 2 f8f8f8f8
e 00000440 c 00050005
e 00000444 3 07a507a5
e 00000444 4 05050505
e 00000444 8 f8f8f8f8
e 00000450 f 0005f8a5
e 00000454 f f80507a5
e 00000458 f ffffffa5
e 0000045c f 000000a5
e 00000460 f 00000007
e 00000464 f 00000005
e 00000468 f fffffff8
e 0000046c f 000007a5
e 00000470 f fffff805
e 00000474 f 0000f805
e 000004fc f c0de5000

// File: rv_core.f
hw/rv_pkg.sv
hw/rv_decoder.sv
hw/rv_regfile.sv
hw/rv_alu.sv
hw/rv_mem_port.sv
hw/rv_core.sv
bench/core_checker.sv
bench/core_monitor.sv
bench/tb_core.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module tb_core -f rv_core.f -o sim_core
status=0
out=$(./obj_dir/sim_core 2>&1) || status=$?
echo "$out"
[ "$status" -eq 0 ]
echo "$out" | grep -q "SIMULATION PASSED"
